/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_cache \
		-f sim.f -o tb_cache
	./obj_dir/tb_cache | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

/* cache_cases.txt */
// op (0 idle, 1 read, 2 write), word address, write data
// all fields hex, one operation per line
0 00000000 00000000
1 00000100 00000000
1 00000101 00000000
2 00000102 cafe0001
1 00000102 00000000
1 00000103 00000000
1 00000200 00000000
1 00000300 00000000
0 00000000 00000000
1 00000400 00000000
2 00000501 5a5a0501
1 00000600 00000000
1 00000700 00000000
2 00000802 0bad0802
1 00000803 00000000
1 00000900 00000000
1 00000a00 00000000
1 00000102 00000000
2 00000b03 beef0b03
1 00000501 00000000
1 00000c00 00000000
1 00000d00 00000000
0 00000000 00000000
1 00000e00 00000000
1 00000f00 00000000
1 00000502 00000000
1 00000501 00000000
1 00000802 00000000
2 00000b00 11110b00
2 00000b01 22220b01
1 00000b03 00000000
2 00001000 33331000
2 00001001 44441001
1 00001104 00000000
1 00001208 00000000
1 0000130c 00000000
1 00000b01 00000000
1 00001001 00000000
2 00000100 55550100
1 00000101 00000000
1 00000102 00000000
0 00000000 00000000

/* cache_ctrl_fsm.sv */
// cache controller FSM, sequences write-back and allocate on a miss and drives stall
`timescale 1ns/1ps

module cache_ctrl_fsm import cache_pkg::*; (
	input  logic clk,
	input  logic proc_reset,
	input  logic proc_read,
	input  logic proc_write,
	input  logic hit,
	input  logic victim_dirty,
	input  logic mem_ready,
	output logic proc_stall,
	output logic mem_read,
	output logic mem_write,
	output logic invalidate_all,
	output logic word_write,
	output logic in_write_back,
	output logic fill,
	output logic advance
);

	cache_state_t state;
	cache_state_t state_next;

	// any processor access this cycle
	logic request;
	// compare cycle that completes without memory
	logic serve;

	assign request = proc_read | proc_write;
	assign serve   = (state == st_compare) && (hit || !request);

	// ====================
	// state register
	// ====================
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= st_init;
		end else begin
			state <= state_next;
		end
	end

	// ====================
	// next state
	// ====================
	always_comb begin
		state_next = state;
		case (state)
			// one cycle to wipe the tags
			st_init: begin
				state_next = st_compare;
			end
			st_compare: begin
				// miss, flush the victim first if it holds dirty data
				if (request && !hit) begin
					state_next = victim_dirty ? st_write_back : st_allocate;
				end
			end
			// hold until memory takes the line
			st_write_back: begin
				if (mem_ready) begin
					state_next = st_allocate;
				end
			end
			// hold until the new line arrives, then retry the compare
			st_allocate: begin
				if (mem_ready) begin
					state_next = st_compare;
				end
			end
			default: begin
				state_next = st_init;
			end
		endcase
	end

	// ====================
	// outputs
	// ====================

	// stall everywhere except a hit or an idle compare
	assign proc_stall = !serve;

	// memory requests follow the state, dropped one cycle after ready
	assign mem_write = (state == st_write_back);
	assign mem_read  = (state == st_allocate);

	// line store strobes
	assign invalidate_all = (state == st_init);
	assign word_write     = (state == st_compare) && hit && proc_write;
	assign in_write_back  = (state == st_write_back);
	assign fill           = (state == st_allocate) && mem_ready;
	// pointer steps together with the fill
	assign advance        = fill;

endmodule

/* cache_pkg.sv */
// cache package with the shared widths, way count and controller state encoding
package cache_pkg;

	// ====================
	// processor side
	// ====================

	// word address, byte offset already stripped
	localparam int addr_w = 30;
	localparam int word_w = 32;

	// ====================
	// line geometry
	// ====================

	localparam int words_per_line = 4;
	// selects a word inside a line
	localparam int offset_w = 2;
	localparam int line_w = word_w * words_per_line;
	// tag is the whole line address, fully associative
	localparam int tag_w = addr_w - offset_w;

	// ====================
	// ways
	// ====================

	localparam int num_ways = 8;
	localparam int way_w = 3;

	// controller states
	// init clears valid and dirty, compare serves hits
	// write back flushes a dirty victim, allocate fills from memory
	typedef enum logic [1:0] {
		st_init,
		st_compare,
		st_write_back,
		st_allocate
	} cache_state_t;

endpackage

/* cache_top.sv */
// cache top, ties the miss controller, line store and victim picker together
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
	input  logic                clk,
	input  logic                proc_reset,
	// processor side
	input  logic                proc_read,
	input  logic                proc_write,
	input  logic [addr_w-1:0]   proc_addr,
	input  logic [word_w-1:0]   proc_wdata,
	output logic [word_w-1:0]   proc_rdata,
	output logic                proc_stall,
	// memory side
	output logic                mem_read,
	output logic                mem_write,
	output logic [tag_w-1:0]    mem_addr,
	output logic [line_w-1:0]   mem_wdata,
	input  logic [line_w-1:0]   mem_rdata,
	input  logic                mem_ready
);

	// store status toward controller and picker
	logic                hit;
	logic                victim_dirty;
	logic [num_ways-1:0] valid_bits;

	// controller strobes
	logic                invalidate_all;
	logic                word_write;
	logic                in_write_back;
	logic                fill;
	logic                advance;

	// replacement choice
	logic [way_w-1:0]    victim_way;

	// ====================
	// miss controller
	// ====================
	cache_ctrl_fsm u_ctrl (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.proc_read      (proc_read),
		.proc_write     (proc_write),
		.hit            (hit),
		.victim_dirty   (victim_dirty),
		.mem_ready      (mem_ready),
		.proc_stall     (proc_stall),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.invalidate_all (invalidate_all),
		.word_write     (word_write),
		.in_write_back  (in_write_back),
		.fill           (fill),
		.advance        (advance)
	);

	// lowest invalid way, else round robin
	victim_select u_victim (
		.clk        (clk),
		.proc_reset (proc_reset),
		.valid_bits (valid_bits),
		.advance    (advance),
		.victim_way (victim_way)
	);

	// ====================
	// tag and data arrays
	// ====================
	line_store u_store (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.proc_addr      (proc_addr),
		.proc_wdata     (proc_wdata),
		.proc_read      (proc_read),
		.proc_write     (proc_write),
		.invalidate_all (invalidate_all),
		.word_write     (word_write),
		.in_write_back  (in_write_back),
		.fill           (fill),
		.victim_way     (victim_way),
		.mem_rdata      (mem_rdata),
		.hit            (hit),
		.victim_dirty   (victim_dirty),
		.valid_bits     (valid_bits),
		.proc_rdata     (proc_rdata),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata)
	);

endmodule

/* line_store.sv */
// line store, valid/dirty/tag/data arrays with hit detect, word merge, fill and flush
`timescale 1ns/1ps

module line_store import cache_pkg::*; (
	input  logic                clk,
	input  logic                proc_reset,
	// processor request
	input  logic [addr_w-1:0]   proc_addr,
	input  logic [word_w-1:0]   proc_wdata,
	input  logic                proc_read,
	input  logic                proc_write,
	// controller strobes
	input  logic                invalidate_all,
	input  logic                word_write,
	input  logic                in_write_back,
	input  logic                fill,
	input  logic [way_w-1:0]    victim_way,
	input  logic [line_w-1:0]   mem_rdata,
	// status
	output logic                hit,
	output logic                victim_dirty,
	output logic [num_ways-1:0] valid_bits,
	// data paths
	output logic [word_w-1:0]   proc_rdata,
	output logic [tag_w-1:0]    mem_addr,
	output logic [line_w-1:0]   mem_wdata
);

	// ====================
	// storage
	// ====================
	logic [num_ways-1:0] valid;
	logic [num_ways-1:0] dirty;
	logic [tag_w-1:0]    tag  [num_ways];
	logic [word_w-1:0]   data [num_ways][words_per_line];

	// request split into line address and word offset
	logic [tag_w-1:0]    req_tag;
	logic [offset_w-1:0] req_offset;

	logic [num_ways-1:0] way_hit;
	logic [way_w-1:0]    hit_way;

	assign req_tag    = proc_addr[addr_w-1:offset_w];
	assign req_offset = proc_addr[offset_w-1:0];

	// ====================
	// tag compare
	// ====================
	always_comb begin
		for (int i = 0; i < num_ways; i++) begin
			way_hit[i] = valid[i] && (tag[i] == req_tag);
		end
	end

	// tags are unique among valid ways, at most one bit set
	always_comb begin
		hit_way = '0;
		for (int i = 0; i < num_ways; i++) begin
			if (way_hit[i]) begin
				hit_way = way_w'(i);
			end
		end
	end

	// no request, no hit
	assign hit = (proc_read | proc_write) && (|way_hit);

	// word read, valid only when hit is high
	assign proc_rdata = data[hit_way][req_offset];

	assign valid_bits   = valid;
	assign victim_dirty = dirty[victim_way];

	// ====================
	// memory side
	// ====================
	// victim tag while flushing, else the missing line address
	assign mem_addr = in_write_back ? tag[victim_way] : req_tag;

	// word 0 sits in the low bits of the line
	always_comb begin
		for (int k = 0; k < words_per_line; k++) begin
			mem_wdata[k*word_w +: word_w] = data[victim_way][k];
		end
	end

	// ====================
	// valid and dirty
	// ====================
	always_ff @(posedge clk) begin
		if (proc_reset || invalidate_all) begin
			valid <= '0;
			dirty <= '0;
		end else if (fill) begin
			// fresh line, clean
			valid[victim_way] <= 1'b1;
			dirty[victim_way] <= 1'b0;
		end else if (word_write) begin
			dirty[hit_way] <= 1'b1;
		end else if (in_write_back) begin
			// victim is clean once its line is handed to memory
			dirty[victim_way] <= 1'b0;
		end
	end

	// ====================
	// tag and data update
	// ====================
	always_ff @(posedge clk) begin
		if (fill) begin
			tag[victim_way] <= req_tag;
			for (int k = 0; k < words_per_line; k++) begin
				data[victim_way][k] <= mem_rdata[k*word_w +: word_w];
			end
		end else if (word_write) begin
			// merge one word, the rest of the line stays
			data[hit_way][req_offset] <= proc_wdata;
		end
	end

endmodule

/* sim.f */
cache_pkg.sv
victim_select.sv
line_store.sv
cache_ctrl_fsm.sv
cache_top.sv
tb_cache.sv

/* tb_cache.sv */
// cache testbench playing file cases against a line-level memory model and a reference mirror
`timescale 1ns/1ps

module tb_cache;

	localparam int addr_w = cache_pkg::addr_w;
	localparam int word_w = cache_pkg::word_w;
	localparam int line_w = cache_pkg::line_w;
	// line address with the word offset dropped
	localparam int tag_w = addr_w - 2;
	localparam int ways = 8;
	localparam int max_cases = 64;
	localparam int clk_ns = 8;
	localparam int reset_cycles = 10;
	// memory preset where each word is its own address plus this
	localparam logic [word_w-1:0] fill_offset = 32'h1000_0000;
	// op codes in the case file
	localparam logic [31:0] op_idle  = 32'd0;
	localparam logic [31:0] op_read  = 32'd1;
	localparam logic [31:0] op_write = 32'd2;

	logic              clk = 1'b0;
	logic              proc_reset;
	logic              proc_read;
	logic              proc_write;
	logic [addr_w-1:0] proc_addr;
	logic [word_w-1:0] proc_wdata;
	logic [word_w-1:0] proc_rdata;
	logic              proc_stall;
	logic              mem_read;
	logic              mem_write;
	logic [tag_w-1:0]  mem_addr;
	logic [line_w-1:0] mem_wdata;
	logic [line_w-1:0] mem_rdata;
	logic              mem_ready;

	// three words per case as op then address then data
	logic [31:0] case_words [0:3*max_cases-1];
	int          num_cases;
	int          cur_case;
	bit          cases_loaded;
	int          errors;

	// processor view of memory holding only written words
	logic [word_w-1:0] shadow [logic [addr_w-1:0]];
	// lines the cache wrote back
	logic [line_w-1:0] mem_lines [logic [tag_w-1:0]];

	// reference mirror of the eight ways
	logic             ref_valid [ways];
	logic             ref_dirty [ways];
	logic [tag_w-1:0] ref_tag   [ways];
	int               rr_ptr;

	logic [15:0] lfsr_state;

	always #(clk_ns / 2) clk = ~clk;

	cache_top dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	// ====================
	// helpers
	// ====================

	// galois step per random bit taken
	function automatic logic next_rand_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 16'hb400;
		end
		return lfsr_state[0];
	endfunction

	// untouched memory holds word address plus offset
	function automatic logic [line_w-1:0] pattern_line(input logic [tag_w-1:0] t);
		logic [line_w-1:0] l;
		logic [addr_w-1:0] a;
		for (int k = 0; k < 4; k++) begin
			a = {t, 2'(k)};
			l[k*word_w +: word_w] = word_w'(a) + fill_offset;
		end
		return l;
	endfunction

	function automatic logic [word_w-1:0] expected_word(input logic [addr_w-1:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return word_w'(a) + fill_offset;
	endfunction

	// what a cached line must hold word by word
	function automatic logic [line_w-1:0] mirror_line(input logic [tag_w-1:0] t);
		logic [line_w-1:0] l;
		for (int k = 0; k < 4; k++) begin
			l[k*word_w +: word_w] = expected_word({t, 2'(k)});
		end
		return l;
	endfunction

	task automatic check_quiet(input string what);
		if (proc_stall !== 1'b1) begin
			errors++;
			$display("mismatch proc_stall (%s): expected 1 got %h", what, proc_stall);
		end
		if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
			errors++;
			$display("mismatch mem_read/mem_write (%s): expected 0/0 got %h/%h",
				what, mem_read, mem_write);
		end
	endtask

	// ====================
	// memory model
	// ====================
	// one-cycle ready after 1 to 4 cycles
	initial begin
		int wait_cnt;
		bit busy;
		mem_ready = 1'b0;
		mem_rdata = '0;
		busy = 1'b0;
		wait_cnt = 0;
		forever begin
			@(posedge clk);
			#1;
			if (mem_ready) begin
				mem_ready = 1'b0;
				busy = 1'b0;
			end else if (mem_read || mem_write) begin
				if (!busy) begin
					busy = 1'b1;
					wait_cnt = 0;
					if (next_rand_bit()) begin
						wait_cnt += 1;
					end
					if (next_rand_bit()) begin
						wait_cnt += 2;
					end
				end
				if (wait_cnt == 0) begin
					if (mem_write) begin
						mem_lines[mem_addr] = mem_wdata;
					end else if (mem_lines.exists(mem_addr)) begin
						mem_rdata = mem_lines[mem_addr];
					end else begin
						mem_rdata = pattern_line(mem_addr);
					end
					mem_ready = 1'b1;
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	// ====================
	// one case
	// ====================
	// called 1 ns after an edge and returns at the negedge before the completing edge
	task automatic run_case(input logic [31:0] op, input logic [addr_w-1:0] addr,
		input logic [word_w-1:0] wdata);
		logic [tag_w-1:0] t;
		logic             is_hit;
		logic             all_valid;
		logic             exp_wb;
		logic             saw_read;
		logic             saw_write;
		logic             done;
		int               way;
		int               victim;
		int               stall_cycles;

		proc_read = (op == op_read);
		proc_write = (op == op_write);
		proc_addr = addr;
		proc_wdata = wdata;

		// idle compare has no stall and no memory traffic
		if (op == op_idle) begin
			@(negedge clk);
			if (proc_stall !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
				errors++;
				$display("mismatch proc_stall/mem_read/mem_write case %0d: %s %h/%h/%h",
					cur_case, "expected 0/0/0 got", proc_stall, mem_read, mem_write);
			end
			return;
		end

		// predict hit or victim from the mirror
		t = addr[addr_w-1:2];
		is_hit = 1'b0;
		way = 0;
		for (int i = 0; i < ways; i++) begin
			if (ref_valid[i] && ref_tag[i] == t) begin
				is_hit = 1'b1;
				way = i;
			end
		end
		all_valid = 1'b1;
		victim = rr_ptr;
		for (int i = ways - 1; i >= 0; i--) begin
			if (!ref_valid[i]) begin
				all_valid = 1'b0;
				victim = i;
			end
		end
		exp_wb = !is_hit && ref_valid[victim] && ref_dirty[victim];

		saw_read = 1'b0;
		saw_write = 1'b0;
		done = 1'b0;
		stall_cycles = 0;
		while (!done) begin
			@(negedge clk);
			// first cycle of the write-back phase
			if (mem_write && !saw_write) begin
				if (!exp_wb) begin
					errors++;
					$display("case %0d wrote back a line that should not be written", cur_case);
				end else begin
					if (mem_addr !== ref_tag[victim]) begin
						errors++;
						$display("mismatch mem_addr case %0d: expected %h got %h",
							cur_case, ref_tag[victim], mem_addr);
					end
					if (mem_wdata !== mirror_line(ref_tag[victim])) begin
						errors++;
						$display("mismatch mem_wdata case %0d: expected %h got %h",
							cur_case, mirror_line(ref_tag[victim]), mem_wdata);
					end
				end
				if (saw_read) begin
					errors++;
					$display("case %0d wrote back after the fill read", cur_case);
				end
				saw_write = 1'b1;
			end
			// first cycle of the fill phase
			if (mem_read && !saw_read) begin
				if (is_hit) begin
					errors++;
					$display("case %0d read memory on a hit", cur_case);
				end
				if (exp_wb && !saw_write) begin
					errors++;
					$display("case %0d read memory before writing back the dirty victim",
						cur_case);
				end
				if (mem_addr !== t) begin
					errors++;
					$display("mismatch mem_addr case %0d: expected %h got %h", cur_case, t, mem_addr);
				end
				saw_read = 1'b1;
			end
			if (proc_stall === 1'b0) begin
				// a completing cycle carries no memory request
				if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
					errors++;
					$display("case %0d completed while a memory request was still up",
						cur_case);
				end
				done = 1'b1;
			end else begin
				stall_cycles++;
			end
		end

		if (is_hit && stall_cycles != 0) begin
			errors++;
			$display("hit in case %0d stalled for %0d cycles", cur_case, stall_cycles);
		end
		if (!is_hit && !saw_read) begin
			errors++;
			$display("miss in case %0d finished without a memory read", cur_case);
		end
		if (exp_wb && !saw_write) begin
			errors++;
			$display("dirty victim in case %0d was never written back", cur_case);
		end
		if (op == op_read && proc_rdata !== expected_word(addr)) begin
			errors++;
			$display("mismatch proc_rdata case %0d: expected %h got %h",
				cur_case, expected_word(addr), proc_rdata);
		end

		// mirror update where the pointer moves only on a full cache
		if (!is_hit) begin
			if (all_valid) begin
				rr_ptr = (rr_ptr + 1) % ways;
			end
			ref_valid[victim] = 1'b1;
			ref_dirty[victim] = 1'b0;
			ref_tag[victim] = t;
			way = victim;
		end
		if (op == op_write) begin
			ref_dirty[way] = 1'b1;
			shadow[addr] = wdata;
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		lfsr_state = 16'd41924;
		errors = 0;
		cur_case = 0;
		rr_ptr = 0;
		for (int i = 0; i < ways; i++) begin
			ref_valid[i] = 1'b0;
			ref_dirty[i] = 1'b0;
			ref_tag[i] = '0;
		end

		// all ones marks the end of the loaded cases
		for (int i = 0; i < 3 * max_cases; i++) begin
			case_words[i] = 32'hffff_ffff;
		end
		$readmemh("cache_cases.txt", case_words);
		num_cases = 0;
		while (num_cases < max_cases && case_words[3*num_cases] != 32'hffff_ffff) begin
			num_cases++;
		end
		if (num_cases == 0) begin
			errors++;
			$display("no cases were read from cache_cases.txt");
		end
		cases_loaded = 1'b1;

		// last pass drops reset and checks the init cycle
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
			#1;
			if (i == reset_cycles - 1) begin
				proc_reset = 1'b0;
			end
			@(negedge clk);
			check_quiet(i == reset_cycles - 1 ? "init" : "reset");
		end

		for (cur_case = 0; cur_case < num_cases; cur_case++) begin
			@(posedge clk);
			#1;
			run_case(case_words[3*cur_case], case_words[3*cur_case+1][addr_w-1:0],
				case_words[3*cur_case+2]);
		end
		@(posedge clk);
		#1;
		proc_read = 1'b0;
		proc_write = 1'b0;

		$display("cases %0d, errors %0d", num_cases, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog allowing 40 cycles per case plus reset
	initial begin
		int limit_ns;
		wait (cases_loaded);
		limit_ns = num_cases * 40 * clk_ns + (reset_cycles + 2) * clk_ns;
		#(limit_ns);
		$display("timeout after %0d ns, case %0d of %0d never finished",
			limit_ns, cur_case, num_cases);
		$display("Something failed");
		$finish;
	end

endmodule

/* victim_select.sv */
// victim picker choosing the first invalid way or else a round-robin pointer
`timescale 1ns/1ps

module victim_select import cache_pkg::*; (
	input  logic                clk,
	input  logic                proc_reset,
	input  logic [num_ways-1:0] valid_bits,
	input  logic                advance,
	output logic [way_w-1:0]    victim_way
);

	logic [way_w-1:0] rr_ptr;
	logic [way_w-1:0] first_invalid;
	logic             any_invalid;

	assign any_invalid = ~&valid_bits;

	// priority encode scanning from the top so the lowest invalid way wins
	always_comb begin
		first_invalid = '0;
		for (int i = num_ways - 1; i >= 0; i--) begin
			if (!valid_bits[i]) begin
				first_invalid = way_w'(i);
			end
		end
	end

	assign victim_way = any_invalid ? first_invalid : rr_ptr;

	// ====================
	// round robin pointer
	// ====================
	// only moves when a full cache had to evict
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			rr_ptr <= '0;
		end else if (advance && !any_invalid) begin
			if (rr_ptr == way_w'(num_ways - 1)) begin
				rr_ptr <= '0;
			end else begin
				rr_ptr <= rr_ptr + way_w'(1);
			end
		end
	end

endmodule
